// File: common/rv_core_pkg.sv
package rv_core_pkg;

  // ----------------------------------------------------------
  // Data path
  // ----------------------------------------------------------

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;

  // First fetch address out of reset
  localparam word_t RESET_PC = 32'h0000_0000;

  // Architectural registers, x0 included
  localparam int NUM_REGS = 32;

  // One strobe bit per byte lane
  localparam int STRB_W = XLEN / 8;

  // ----------------------------------------------------------
  // Execute controls
  // ----------------------------------------------------------

  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_SLT    = 3'd5,
    ALU_PASS_B = 3'd6
  } alu_op_e;

  // Write-back source
  typedef enum logic [1:0] {
    RES_ALU = 2'd0,
    RES_MEM = 2'd1,
    RES_PC4 = 2'd2
  } res_src_e;

endpackage

// File: common/rv_ctrl_if.sv
`timescale 1ns/100ps

interface rv_ctrl_if;
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  // ALU setup
  alu_op_e           alu_op;
  logic              alu_b_imm;
  // Write-back
  res_src_e          res_src;
  logic              reg_write;
  logic [REG_AW-1:0] rd;
  // Data memory
  logic              mem_read;
  logic              mem_write;
  // Control flow
  logic              is_branch;
  logic              branch_ne;
  logic              is_jal;
  // Selected immediate for this format
  word_t             imm;
  // Encoding outside the supported subset
  logic              illegal;

  modport decode (
    output alu_op, alu_b_imm, res_src, reg_write, mem_read, mem_write,
           is_branch, branch_ne, is_jal, imm, rd, illegal
  );

  modport execute (
    input alu_op, alu_b_imm, res_src, reg_write, mem_read, mem_write,
          is_branch, branch_ne, is_jal, imm, rd, illegal
  );

endinterface

// File: common/rv_isa_pkg.sv
package rv_isa_pkg;

  // ----------------------------------------------------------
  // Major opcodes of the supported RV32I subset
  // ----------------------------------------------------------

  typedef enum logic [6:0] {
    OP_RTYPE  = 7'b0110011,
    OP_ITYPE  = 7'b0010011,
    OP_LUI    = 7'b0110111,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  // ALU funct3 values (R-type and ADDI)
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // Branch funct3 values
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  // Only word-sized loads and stores
  localparam logic [2:0] F3_WORD = 3'b010;

  // funct7 that turns ADD into SUB
  localparam logic [6:0] FUNCT7_SUB = 7'b0100000;

  // EBREAK is a single fixed encoding in the SYSTEM space
  localparam logic [31:0] EBREAK_INSTR = 32'h0010_0073;

  // Trap causes seen by the execute stage
  typedef enum logic [1:0] {
    TRAP_NONE          = 2'd0,
    TRAP_INSTR_INVALID = 2'd1,
    TRAP_MISALIGNED    = 2'd2
  } trap_code_e;

  // ----------------------------------------------------------
  // Register address fields
  // ----------------------------------------------------------

  localparam int REG_AW  = 5;
  localparam int RD_LSB  = 7;
  localparam int RS1_LSB = 15;
  localparam int RS2_LSB = 20;

endpackage

// File: decode/rv_decode.sv
`timescale 1ns/100ps

module rv_decode (
  input  rv_core_pkg::word_t            instr,
  input  logic                          halt,
  output logic [rv_isa_pkg::REG_AW-1:0] rs1_addr,
  output logic [rv_isa_pkg::REG_AW-1:0] rs2_addr,
  output logic                          ebreak_hit,
  rv_ctrl_if.decode                     ctrl
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       is_ebreak;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;

  // ----------------------------------------------------------
  // Instruction fields
  // ----------------------------------------------------------

  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign rs1_addr = instr[RS1_LSB +: REG_AW];
  assign rs2_addr = instr[RS2_LSB +: REG_AW];
  assign ctrl.rd  = instr[RD_LSB +: REG_AW];

  // EBREAK stops the core but is not a trap
  assign is_ebreak  = (instr == EBREAK_INSTR);
  assign ebreak_hit = is_ebreak && !halt;

  // ----------------------------------------------------------
  // Immediates, all sign extended from bit 31
  // ----------------------------------------------------------

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  // B and J offsets are in half-words so bit 0 is always zero
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};

  // ----------------------------------------------------------
  // Control decode
  // ----------------------------------------------------------

  always_comb begin
    // Idle bundle unless an opcode below claims it
    ctrl.alu_op    = ALU_ADD;
    ctrl.alu_b_imm = 1'b0;
    ctrl.res_src   = RES_ALU;
    ctrl.reg_write = 1'b0;
    ctrl.mem_read  = 1'b0;
    ctrl.mem_write = 1'b0;
    ctrl.is_branch = 1'b0;
    ctrl.branch_ne = 1'b0;
    ctrl.is_jal    = 1'b0;
    ctrl.imm       = '0;
    ctrl.illegal   = 1'b0;

    case (opcode)
      OP_RTYPE: begin
        ctrl.reg_write = 1'b1;
        if ((funct7 == FUNCT7_SUB) && (funct3 == F3_ADD_SUB)) begin
          ctrl.alu_op = ALU_SUB;
        end else if (funct7 != 7'b0000000) begin
          ctrl.illegal = 1'b1;
        end else begin
          case (funct3)
            F3_ADD_SUB: ctrl.alu_op = ALU_ADD;
            F3_SLT:     ctrl.alu_op = ALU_SLT;
            F3_XOR:     ctrl.alu_op = ALU_XOR;
            F3_OR:      ctrl.alu_op = ALU_OR;
            F3_AND:     ctrl.alu_op = ALU_AND;
            default:    ctrl.illegal = 1'b1;
          endcase
        end
      end
      // ADDI only
      OP_ITYPE: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        ctrl.imm       = imm_i;
        ctrl.illegal   = (funct3 != F3_ADD_SUB);
      end
      // LUI passes the U immediate straight through the ALU
      OP_LUI: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        ctrl.alu_op    = ALU_PASS_B;
        ctrl.imm       = imm_u;
      end
      OP_LOAD: begin
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        ctrl.res_src   = RES_MEM;
        ctrl.imm       = imm_i;
        ctrl.illegal   = (funct3 != F3_WORD);
      end
      OP_STORE: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        ctrl.imm       = imm_s;
        ctrl.illegal   = (funct3 != F3_WORD);
      end
      OP_BRANCH: begin
        ctrl.is_branch = 1'b1;
        ctrl.imm       = imm_b;
        case (funct3)
          F3_BEQ:  ctrl.branch_ne = 1'b0;
          F3_BNE:  ctrl.branch_ne = 1'b1;
          default: ctrl.illegal = 1'b1;
        endcase
      end
      // Link register gets pc + 4
      OP_JAL: begin
        ctrl.is_jal    = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.res_src   = RES_PC4;
        ctrl.imm       = imm_j;
      end
      // Nothing but EBREAK lives here
      OP_SYSTEM: ctrl.illegal = !is_ebreak;
      default:   ctrl.illegal = 1'b1;
    endcase
  end

endmodule

// File: logic/rv_core.sv
`timescale 1ns/100ps

module rv_core (
  input  logic                           clk,
  input  logic                           rst_n,
  // Instruction memory
  output logic                           imem_ren,
  output rv_core_pkg::word_t             imem_raddr,
  input  rv_core_pkg::word_t             imem_rdata,
  // Data memory reads
  output logic                           dmem_ren,
  output rv_core_pkg::word_t             dmem_raddr,
  input  rv_core_pkg::word_t             dmem_rdata,
  // Data memory writes
  output logic                           dmem_we,
  output rv_core_pkg::word_t             dmem_waddr,
  output rv_core_pkg::word_t             dmem_wdata,
  output logic [rv_core_pkg::STRB_W-1:0] dmem_wstrb,
  // Sticky status
  output logic                           ebreak,
  output logic                           trap
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  // PC control
  word_t pc;
  word_t pc_plus4;
  logic  halt;

  // Execute back to PC control
  logic  redirect;
  word_t redirect_target;
  logic  ebreak_hit;
  logic  trap_hit;

  // Register file ports
  logic [REG_AW-1:0] rs1_addr;
  logic [REG_AW-1:0] rs2_addr;
  word_t             rs1_data;
  word_t             rs2_data;
  logic              rd_we;
  word_t             rd_data;

  // Decoded control bundle
  rv_ctrl_if ctrl_if ();

  // Fetch address is the current PC
  assign imem_raddr = pc;

  // ----------------------------------------------------------
  // Single-cycle chain
  // ----------------------------------------------------------

  rv_pc_ctrl pc_ctrl0 (
    .clk             (clk),
    .rst_n           (rst_n),
    .redirect        (redirect),
    .redirect_target (redirect_target),
    .ebreak_hit      (ebreak_hit),
    .trap_hit        (trap_hit),
    .pc              (pc),
    .pc_plus4        (pc_plus4),
    .halt            (halt),
    .imem_ren        (imem_ren),
    .ebreak          (ebreak),
    .trap            (trap)
  );

  rv_decode decode0 (
    .instr      (imem_rdata),
    .halt       (halt),
    .rs1_addr   (rs1_addr),
    .rs2_addr   (rs2_addr),
    .ebreak_hit (ebreak_hit),
    .ctrl       (ctrl_if)
  );

  // Destination register comes straight from the decoded bundle
  rv_regfile regfile0 (
    .clk      (clk),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (ctrl_if.rd),
    .rd_we    (rd_we),
    .rd_data  (rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_execute execute0 (
    .ctrl            (ctrl_if),
    .rs1_data        (rs1_data),
    .rs2_data        (rs2_data),
    .pc              (pc),
    .pc_plus4        (pc_plus4),
    .dmem_rdata      (dmem_rdata),
    .halt            (halt),
    .rd_we           (rd_we),
    .rd_data         (rd_data),
    .redirect        (redirect),
    .redirect_target (redirect_target),
    .trap_hit        (trap_hit),
    .dmem_ren        (dmem_ren),
    .dmem_raddr      (dmem_raddr),
    .dmem_we         (dmem_we),
    .dmem_waddr      (dmem_waddr),
    .dmem_wdata      (dmem_wdata),
    .dmem_wstrb      (dmem_wstrb)
  );

endmodule

// File: logic/rv_execute.sv
`timescale 1ns/100ps

module rv_execute (
  rv_ctrl_if.execute                     ctrl,
  input  rv_core_pkg::word_t             rs1_data,
  input  rv_core_pkg::word_t             rs2_data,
  input  rv_core_pkg::word_t             pc,
  input  rv_core_pkg::word_t             pc_plus4,
  input  rv_core_pkg::word_t             dmem_rdata,
  input  logic                           halt,
  output logic                           rd_we,
  output rv_core_pkg::word_t             rd_data,
  output logic                           redirect,
  output rv_core_pkg::word_t             redirect_target,
  output logic                           trap_hit,
  output logic                           dmem_ren,
  output rv_core_pkg::word_t             dmem_raddr,
  output logic                           dmem_we,
  output rv_core_pkg::word_t             dmem_waddr,
  output rv_core_pkg::word_t             dmem_wdata,
  output logic [rv_core_pkg::STRB_W-1:0] dmem_wstrb
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  word_t      alu_b;
  word_t      alu_result;
  word_t      jb_target;
  logic       operands_eq;
  logic       take_jump;
  logic       addr_misaligned;
  logic       target_misaligned;
  logic       commit;
  trap_code_e trap_code;

  // ----------------------------------------------------------
  // ALU
  // ----------------------------------------------------------

  assign alu_b = ctrl.alu_b_imm ? ctrl.imm : rs2_data;

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:    alu_result = rs1_data + alu_b;
      ALU_SUB:    alu_result = rs1_data - alu_b;
      ALU_AND:    alu_result = rs1_data & alu_b;
      ALU_OR:     alu_result = rs1_data | alu_b;
      ALU_XOR:    alu_result = rs1_data ^ alu_b;
      // Signed compare, result is 0 or 1
      ALU_SLT:    alu_result = {{(XLEN-1){1'b0}}, ($signed(rs1_data) < $signed(alu_b))};
      ALU_PASS_B: alu_result = alu_b;
      default:    alu_result = '0;
    endcase
  end

  // ----------------------------------------------------------
  // Branches and jumps
  // ----------------------------------------------------------

  assign operands_eq = (rs1_data == rs2_data);

  // BNE inverts the equality test
  assign take_jump = (ctrl.is_branch && (operands_eq != ctrl.branch_ne)) || ctrl.is_jal;

  // Both B and J targets are pc relative
  assign jb_target = pc + ctrl.imm;

  // ----------------------------------------------------------
  // Traps
  // ----------------------------------------------------------

  // Word accesses need the two low address bits clear
  assign addr_misaligned = (ctrl.mem_read || ctrl.mem_write) && (alu_result[1:0] != 2'b00);

  // A half-word aligned jump target would fetch off the word grid
  assign target_misaligned = take_jump && (jb_target[1:0] != 2'b00);

  always_comb begin
    if (ctrl.illegal) begin
      trap_code = TRAP_INSTR_INVALID;
    end else if (addr_misaligned || target_misaligned) begin
      trap_code = TRAP_MISALIGNED;
    end else begin
      trap_code = TRAP_NONE;
    end
  end

  assign trap_hit = !halt && (trap_code != TRAP_NONE);

  // Instruction may change state only when running and not trapping
  assign commit = !halt && (trap_code == TRAP_NONE);

  assign redirect        = take_jump && commit;
  assign redirect_target = jb_target;

  // ----------------------------------------------------------
  // Data memory
  // ----------------------------------------------------------

  assign dmem_ren   = ctrl.mem_read && commit;
  assign dmem_raddr = alu_result;

  assign dmem_we    = ctrl.mem_write && commit;
  assign dmem_waddr = alu_result;
  assign dmem_wdata = rs2_data;
  // Word stores only
  assign dmem_wstrb = '1;

  // ----------------------------------------------------------
  // Write-back
  // ----------------------------------------------------------

  always_comb begin
    case (ctrl.res_src)
      RES_MEM: rd_data = dmem_rdata;
      RES_PC4: rd_data = pc_plus4;
      default: rd_data = alu_result;
    endcase
  end

  assign rd_we = ctrl.reg_write && commit;

  // Decode never marks one instruction as both load and store
  always_comb begin
    a_no_rw_overlap: assert (!((dmem_we === 1'b1) && (dmem_ren === 1'b1)));
  end

endmodule

// File: logic/rv_pc_ctrl.sv
`timescale 1ns/100ps

module rv_pc_ctrl (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               redirect,
  input  rv_core_pkg::word_t redirect_target,
  input  logic               ebreak_hit,
  input  logic               trap_hit,
  output rv_core_pkg::word_t pc,
  output rv_core_pkg::word_t pc_plus4,
  output logic               halt,
  output logic               imem_ren,
  output logic               ebreak,
  output logic               trap
);
  import rv_core_pkg::*;

  word_t pc_next;
  logic  halt_next;

  // ----------------------------------------------------------
  // Next PC
  // ----------------------------------------------------------

  assign pc_plus4 = pc + 32'd4;

  // Taken branch or JAL wins over sequential fetch
  assign pc_next = redirect ? redirect_target : pc_plus4;

  // Halt as soon as the current instruction stops the core
  assign halt_next = ebreak_hit || trap_hit || halt;

  // No fetch once halted
  assign imem_ren = !halt;

  // PC stays on the halting instruction
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (!halt_next) begin
      pc <= pc_next;
    end
  end

  // ----------------------------------------------------------
  // Halt and sticky status
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      halt   <= 1'b0;
      ebreak <= 1'b0;
      trap   <= 1'b0;
    end else begin
      halt   <= halt_next;
      ebreak <= ebreak_hit || ebreak;
      trap   <= trap_hit || trap;
    end
  end

  // Redirect targets are checked in execute so fetch stays word aligned
  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00);

endmodule

// File: logic/rv_regfile.sv
`timescale 1ns/100ps

module rv_regfile (
  input  logic                          clk,
  input  logic [rv_isa_pkg::REG_AW-1:0] rs1_addr,
  input  logic [rv_isa_pkg::REG_AW-1:0] rs2_addr,
  input  logic [rv_isa_pkg::REG_AW-1:0] rd_addr,
  input  logic                          rd_we,
  input  rv_core_pkg::word_t            rd_data,
  output rv_core_pkg::word_t            rs1_data,
  output rv_core_pkg::word_t            rs2_data
);
  import rv_core_pkg::*;

  // Entry 0 is never written
  word_t regs [NUM_REGS];

  // ----------------------------------------------------------
  // Write port
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rd_we && (rd_addr != '0)) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // ----------------------------------------------------------
  // Read ports
  // ----------------------------------------------------------

  // x0 reads as zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f rv_core.f \
  --top-module tb_rv_core \
  -o tb_rv_core_sim

./obj_dir/tb_rv_core_sim | tee sim.log

if grep -qx "sim passed" sim.log; then
  echo "run_sim: PASS"
else
  echo "run_sim: FAIL"
  exit 1
fi

// File: rv_core.f
common/rv_isa_pkg.sv
common/rv_core_pkg.sv
common/rv_ctrl_if.sv
logic/rv_pc_ctrl.sv
decode/rv_decode.sv
logic/rv_regfile.sv
logic/rv_execute.sv
logic/rv_core.sv
test/tb_clock.sv
test/tb_rv_core.sv

// File: test/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
  output logic clk
);

  // 40 ns period, starts low
  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

endmodule

// File: test/tb_rv_core.sv
`timescale 1ns/100ps

module tb_rv_core;

  localparam int          TIMEOUT_CYCLES = 200;
  localparam logic [31:0] EBREAK_WORD    = 32'h0010_0073;
  localparam logic [31:0] LFSR_SEED      = 32'h8e5f_a340;
  localparam logic [6:0]  OPC_OPIMM      = 7'b0010011;
  localparam logic [6:0]  OPC_LOAD       = 7'b0000011;

  logic        clk;
  logic        rst_n;
  logic        imem_ren;
  logic [31:0] imem_raddr;
  logic [31:0] imem_rdata;
  logic        dmem_ren;
  logic [31:0] dmem_raddr;
  logic [31:0] dmem_rdata;
  logic        dmem_we;
  logic [31:0] dmem_waddr;
  logic [31:0] dmem_wdata;
  logic [3:0]  dmem_wstrb;
  logic        ebreak;
  logic        trap;

  // Word memories, 1 KiB each
  logic [31:0] imem [0:255];
  logic [31:0] dmem [0:255];
  // Every store seen since reset release
  logic [31:0] wr_addr_q [$];
  logic [3:0]  wr_strb_q [$];
  // Every load seen since reset release
  logic [31:0] rd_addr_q [$];

  logic [31:0] lfsr;
  int          prog_len;
  int          errors;
  int          checks;
  int          tests;

  tb_clock clk_gen0 (.clk(clk));

  rv_core dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_ren   (imem_ren),
    .imem_raddr (imem_raddr),
    .imem_rdata (imem_rdata),
    .dmem_ren   (dmem_ren),
    .dmem_raddr (dmem_raddr),
    .dmem_rdata (dmem_rdata),
    .dmem_we    (dmem_we),
    .dmem_waddr (dmem_waddr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .ebreak     (ebreak),
    .trap       (trap)
  );

  // ----------------------------------------------------------
  // Memory models
  // ----------------------------------------------------------

  // Zero-latency reads
  assign imem_rdata = imem[imem_raddr[9:2]];
  assign dmem_rdata = dmem[dmem_raddr[9:2]];

  // Byte-lane writes on the edge
  always @(posedge clk) begin
    if (dmem_we === 1'b1) begin
      for (int b = 0; b < 4; b++) begin
        if (dmem_wstrb[b]) begin
          dmem[dmem_waddr[9:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
        end
      end
      wr_addr_q.push_back(dmem_waddr);
      wr_strb_q.push_back(dmem_wstrb);
    end
    if (dmem_ren === 1'b1) begin
      rd_addr_q.push_back(dmem_raddr);
    end
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Pattern uses every index bit
  function automatic logic [31:0] fill_word(input logic [7:0] idx);
    return {8'hd1, idx, ~idx, idx ^ 8'h3c};
  endfunction

  // RV32I instruction formats
  function automatic logic [31:0] r_op(input logic [6:0] f7, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_op(input logic [6:0] opc, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  // SW only
  function automatic logic [31:0] s_op(input logic [4:0] rs2, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_op(input logic [2:0] f3, input logic [4:0] rs1,
                                       input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] j_op(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic take_random(output logic [31:0] v);
    int k;
    v = '0;
    for (k = 0; k < 32; k++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic emit(input logic [31:0] w);
    imem[prog_len[7:0]] = w;
    prog_len++;
  endtask

  // LUI then ADDI, upper part rounded for the sign of the low 12 bits
  task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800;
    emit({upper[31:12], rd, 7'b0110111});
    emit(i_op(OPC_OPIMM, 3'b000, rd, rd, value[11:0]));
  endtask

  task automatic clear_memories();
    int i;
    for (i = 0; i < 256; i++) begin
      imem[i[7:0]] = 32'h0;
      dmem[i[7:0]] <= fill_word(i[7:0]);
    end
  endtask

  // Core held in reset while the next program is built
  task automatic start_program();
    @(posedge clk);
    #2;
    rst_n = 1'b0;
    clear_memories();
    prog_len = 0;
  endtask

  task automatic run_program(input string name);
    int n;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    wr_addr_q.delete();
    wr_strb_q.delete();
    rd_addr_q.delete();
    n = 0;
    while ((ebreak !== 1'b1) && (trap !== 1'b1) && (n < TIMEOUT_CYCLES)) begin
      @(negedge clk);
      n++;
    end
    if ((ebreak !== 1'b1) && (trap !== 1'b1)) begin
      errors++;
      $display("%s: core did not halt within %0d cycles", name, TIMEOUT_CYCLES);
    end
  endtask

  task automatic expect_word(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic end_test(input string name, input int base);
    tests++;
    if (errors == base) begin
      $display("%-14s PASS", name);
    end else begin
      $display("%-14s FAIL, %0d errors", name, errors - base);
    end
  endtask

  // ----------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------

  task automatic arith_test();
    int          base;
    int          r;
    int          k;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] slt_exp;
    base = errors;
    for (r = 0; r < 3; r++) begin
      take_random(a);
      take_random(b);
      start_program();
      load_const(5'd1, a);
      load_const(5'd2, b);
      emit(i_op(OPC_OPIMM, 3'b000, 5'd10, 5'd0, 12'h100));
      emit(r_op(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
      emit(r_op(7'h20, 3'b000, 5'd4, 5'd1, 5'd2));
      emit(r_op(7'h00, 3'b111, 5'd5, 5'd1, 5'd2));
      emit(r_op(7'h00, 3'b110, 5'd6, 5'd1, 5'd2));
      emit(r_op(7'h00, 3'b100, 5'd7, 5'd1, 5'd2));
      emit(r_op(7'h00, 3'b010, 5'd8, 5'd1, 5'd2));
      // x3..x8 to 0x100..0x114
      for (k = 0; k < 6; k++) begin
        emit(s_op(5'(3 + k), 5'd10, 12'(4 * k)));
      end
      emit(EBREAK_WORD);
      run_program("arith");
      // Signs differ: the negative one is smaller, else unsigned order
      if (a[31] != b[31]) begin
        slt_exp = {31'b0, a[31]};
      end else begin
        slt_exp = {31'b0, (a < b)};
      end
      expect_word("ebreak", {31'b0, ebreak}, 32'd1);
      expect_word("trap", {31'b0, trap}, 32'd0);
      expect_word("add", dmem[64], a + b);
      expect_word("sub", dmem[65], a - b);
      expect_word("and", dmem[66], a & b);
      expect_word("or", dmem[67], a | b);
      expect_word("xor", dmem[68], a ^ b);
      expect_word("slt", dmem[69], slt_exp);
    end
    end_test("arith", base);
  endtask

  task automatic load_store_test();
    int          base;
    int          i;
    logic [31:0] p0;
    logic [31:0] p1;
    logic [31:0] p2;
    logic [31:0] exp;
    base = errors;
    take_random(p0);
    take_random(p1);
    take_random(p2);
    start_program();
    dmem[80] <= p0;
    dmem[81] <= p1;
    dmem[82] <= p2;
    emit(i_op(OPC_OPIMM, 3'b000, 5'd10, 5'd0, 12'h140));
    emit(i_op(OPC_LOAD, 3'b010, 5'd1, 5'd10, 12'd0));
    emit(i_op(OPC_LOAD, 3'b010, 5'd2, 5'd10, 12'd4));
    emit(i_op(OPC_LOAD, 3'b010, 5'd3, 5'd10, 12'd8));
    emit(r_op(7'h00, 3'b000, 5'd4, 5'd1, 5'd2));
    emit(r_op(7'h00, 3'b100, 5'd5, 5'd4, 5'd3));
    emit(s_op(5'd4, 5'd10, 12'd12));
    emit(s_op(5'd5, 5'd10, 12'd16));
    emit(EBREAK_WORD);
    run_program("load_store");
    expect_word("ebreak", {31'b0, ebreak}, 32'd1);
    // Each LW raises the read enable once
    expect_word("read count", rd_addr_q.size(), 32'd3);
    if (rd_addr_q.size() == 3) begin
      expect_word("first load address", rd_addr_q[0], 32'h140);
      expect_word("second load address", rd_addr_q[1], 32'h144);
      expect_word("third load address", rd_addr_q[2], 32'h148);
    end
    expect_word("write count", wr_addr_q.size(), 32'd2);
    if (wr_addr_q.size() == 2) begin
      expect_word("first store address", wr_addr_q[0], 32'h14c);
      expect_word("second store address", wr_addr_q[1], 32'h150);
      expect_word("first store strobe", {28'b0, wr_strb_q[0]}, 32'hf);
      expect_word("second store strobe", {28'b0, wr_strb_q[1]}, 32'hf);
    end
    // Whole memory, written words included
    for (i = 0; i < 256; i++) begin
      case (i)
        80:      exp = p0;
        81:      exp = p1;
        82:      exp = p2;
        83:      exp = p0 + p1;
        84:      exp = (p0 + p1) ^ p2;
        default: exp = fill_word(i[7:0]);
      endcase
      expect_word($sformatf("dmem[%0d]", i), dmem[i[7:0]], exp);
    end
    end_test("load_store", base);
  endtask

  task automatic control_flow_test();
    int base;
    base = errors;
    start_program();
    emit(i_op(OPC_OPIMM, 3'b000, 5'd1, 5'd0, 12'd5));
    emit(i_op(OPC_OPIMM, 3'b000, 5'd2, 5'd0, 12'd5));
    emit(b_op(3'b000, 5'd1, 5'd2, 13'd8));
    emit(s_op(5'd1, 5'd0, 12'h180));
    emit(b_op(3'b001, 5'd1, 5'd2, 13'd8));
    emit(s_op(5'd2, 5'd0, 12'h184));
    // JAL sits at 0x18, link is 0x1c
    emit(j_op(5'd5, 21'd8));
    emit(s_op(5'd1, 5'd0, 12'h188));
    emit(s_op(5'd5, 5'd0, 12'h18c));
    emit(EBREAK_WORD);
    run_program("control_flow");
    expect_word("ebreak", {31'b0, ebreak}, 32'd1);
    expect_word("write count", wr_addr_q.size(), 32'd2);
    expect_word("store skipped by BEQ", dmem[96], fill_word(8'd96));
    expect_word("store after BNE", dmem[97], 32'd5);
    expect_word("store skipped by JAL", dmem[98], fill_word(8'd98));
    expect_word("JAL link", dmem[99], 32'h18 + 32'd4);
    end_test("control_flow", base);
  endtask

  task automatic ebreak_test();
    int base;
    base = errors;
    start_program();
    emit(i_op(OPC_OPIMM, 3'b000, 5'd1, 5'd0, 12'h055));
    emit(s_op(5'd1, 5'd0, 12'h1c0));
    emit(EBREAK_WORD);
    emit(s_op(5'd1, 5'd0, 12'h1c4));
    run_program("ebreak");
    expect_word("ebreak", {31'b0, ebreak}, 32'd1);
    expect_word("trap", {31'b0, trap}, 32'd0);
    // Core must stay quiet after the halt
    repeat (5) begin
      @(negedge clk);
      expect_word("imem_ren after halt", {31'b0, imem_ren}, 32'd0);
      expect_word("dmem_we after halt", {31'b0, dmem_we}, 32'd0);
      expect_word("dmem_ren after halt", {31'b0, dmem_ren}, 32'd0);
    end
    expect_word("write count", wr_addr_q.size(), 32'd1);
    expect_word("store before EBREAK", dmem[112], 32'h55);
    expect_word("store after EBREAK", dmem[113], fill_word(8'd113));
    end_test("ebreak", base);
  endtask

  task automatic illegal_test();
    int base;
    base = errors;
    start_program();
    emit(i_op(OPC_OPIMM, 3'b000, 5'd1, 5'd0, 12'h066));
    emit(s_op(5'd1, 5'd0, 12'h1d0));
    emit(32'hffff_ffff);
    emit(s_op(5'd1, 5'd0, 12'h1d4));
    emit(EBREAK_WORD);
    run_program("illegal");
    expect_word("trap", {31'b0, trap}, 32'd1);
    expect_word("ebreak", {31'b0, ebreak}, 32'd0);
    expect_word("write count", wr_addr_q.size(), 32'd1);
    expect_word("store before illegal", dmem[116], 32'h66);
    expect_word("store after illegal", dmem[117], fill_word(8'd117));
    end_test("illegal", base);
  endtask

  task automatic misaligned_test();
    int base;
    base = errors;
    start_program();
    emit(i_op(OPC_OPIMM, 3'b000, 5'd1, 5'd0, 12'h077));
    emit(s_op(5'd1, 5'd0, 12'h1e2));
    emit(EBREAK_WORD);
    run_program("misaligned");
    expect_word("trap", {31'b0, trap}, 32'd1);
    expect_word("ebreak", {31'b0, ebreak}, 32'd0);
    expect_word("write count", wr_addr_q.size(), 32'd0);
    expect_word("aligned word", dmem[120], fill_word(8'd120));
    expect_word("next word", dmem[121], fill_word(8'd121));
    end_test("misaligned", base);
  endtask

  // ----------------------------------------------------------
  // Sequence
  // ----------------------------------------------------------

  initial begin
    rst_n    = 1'b0;
    lfsr     = LFSR_SEED;
    prog_len = 0;
    errors   = 0;
    checks   = 0;
    tests    = 0;
    clear_memories();
    arith_test();
    load_store_test();
    control_flow_test();
    ebreak_test();
    illegal_test();
    misaligned_test();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
